// ==== design/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_w = 5;

  // major opcodes
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_branch = 7'b1100011;

  // alu funct3, shared by reg and imm forms
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  localparam logic [2:0] f3_lw = 3'b010; // word only
  localparam logic [2:0] f3_sw = 3'b010;

  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_alt  = 7'b0100000; // sub, sra

endpackage

`default_nettype wire

// ==== design/core_ctrl_pkg.sv ====
`default_nettype none

package core_ctrl_pkg;

  typedef enum logic [3:0] {
    alu_add      = 4'd0,
    alu_sub      = 4'd1,
    alu_sll      = 4'd2,
    alu_srl      = 4'd3,
    alu_sra      = 4'd4,
    alu_and      = 4'd5,
    alu_or       = 4'd6,
    alu_xor      = 4'd7,
    alu_slt      = 4'd8,
    alu_sltu     = 4'd9,
    alu_pass_imm = 4'd10 // lui
  } alu_op_t;

  typedef enum logic [2:0] {
    br_none = 3'd0,
    br_eq   = 3'd1,
    br_ne   = 3'd2,
    br_lt   = 3'd3,
    br_ge   = 3'd4,
    br_ltu  = 3'd5,
    br_geu  = 3'd6
  } branch_t;

  typedef enum logic [1:0] {
    imm_i = 2'd0,
    imm_s = 2'd1,
    imm_b = 2'd2,
    imm_u = 2'd3
  } imm_fmt_t;

endpackage

`default_nettype wire

// ==== design/inst_decoder.sv ====
`default_nettype none

module inst_decoder (
  input  logic [rv_isa_pkg::xlen-1:0]       inst,
  output logic [rv_isa_pkg::reg_addr_w-1:0] rs1,
  output logic [rv_isa_pkg::reg_addr_w-1:0] rs2,
  output logic [rv_isa_pkg::reg_addr_w-1:0] rd,
  output logic [rv_isa_pkg::xlen-1:0]       imm,
  output core_ctrl_pkg::alu_op_t            alu_op,
  output core_ctrl_pkg::branch_t            branch,
  output logic                              use_imm,
  output logic                              reg_write,
  output logic                              mem_read,
  output logic                              mem_write,
  output logic                              illegal
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  core_ctrl_pkg::imm_fmt_t imm_fmt;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign rd     = inst[11:7];

  always_comb begin
    alu_op    = core_ctrl_pkg::alu_add;
    branch    = core_ctrl_pkg::br_none;
    imm_fmt   = core_ctrl_pkg::imm_i;
    use_imm   = 1'b0;
    reg_write = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    illegal   = 1'b0;
    case (opcode)
      rv_isa_pkg::op_reg, rv_isa_pkg::op_imm: begin
        reg_write = 1'b1;
        use_imm   = (opcode == rv_isa_pkg::op_imm);
        case (funct3)
          rv_isa_pkg::f3_add_sub: begin
            if (opcode == rv_isa_pkg::op_reg && funct7 == rv_isa_pkg::funct7_alt) begin
              alu_op = core_ctrl_pkg::alu_sub;
            end else begin
              alu_op = core_ctrl_pkg::alu_add;
            end
          end
          rv_isa_pkg::f3_sll:  alu_op = core_ctrl_pkg::alu_sll;
          rv_isa_pkg::f3_slt:  alu_op = core_ctrl_pkg::alu_slt;
          rv_isa_pkg::f3_sltu: alu_op = core_ctrl_pkg::alu_sltu;
          rv_isa_pkg::f3_xor:  alu_op = core_ctrl_pkg::alu_xor;
          rv_isa_pkg::f3_srl_sra: begin
            if (funct7 == rv_isa_pkg::funct7_alt) begin
              alu_op = core_ctrl_pkg::alu_sra;
            end else begin
              alu_op = core_ctrl_pkg::alu_srl;
            end
          end
          rv_isa_pkg::f3_or:   alu_op = core_ctrl_pkg::alu_or;
          default:             alu_op = core_ctrl_pkg::alu_and;
        endcase
        // funct7 is only a real field for R-type and the imm shifts
        if (opcode == rv_isa_pkg::op_reg || funct3 == rv_isa_pkg::f3_sll ||
            funct3 == rv_isa_pkg::f3_srl_sra) begin
          if (funct7 == rv_isa_pkg::funct7_alt) begin
            illegal = !(funct3 == rv_isa_pkg::f3_srl_sra ||
                        (opcode == rv_isa_pkg::op_reg && funct3 == rv_isa_pkg::f3_add_sub));
          end else if (funct7 != rv_isa_pkg::funct7_base) begin
            illegal = 1'b1;
          end
        end
      end
      rv_isa_pkg::op_load: begin
        use_imm   = 1'b1;
        reg_write = 1'b1;
        mem_read  = 1'b1;
        illegal   = (funct3 != rv_isa_pkg::f3_lw);
      end
      rv_isa_pkg::op_store: begin
        imm_fmt   = core_ctrl_pkg::imm_s;
        use_imm   = 1'b1;
        mem_write = 1'b1;
        illegal   = (funct3 != rv_isa_pkg::f3_sw);
      end
      rv_isa_pkg::op_lui: begin
        imm_fmt   = core_ctrl_pkg::imm_u;
        alu_op    = core_ctrl_pkg::alu_pass_imm;
        use_imm   = 1'b1;
        reg_write = 1'b1;
      end
      rv_isa_pkg::op_branch: begin
        imm_fmt = core_ctrl_pkg::imm_b;
        case (funct3)
          rv_isa_pkg::f3_beq:  branch = core_ctrl_pkg::br_eq;
          rv_isa_pkg::f3_bne:  branch = core_ctrl_pkg::br_ne;
          rv_isa_pkg::f3_blt:  branch = core_ctrl_pkg::br_lt;
          rv_isa_pkg::f3_bge:  branch = core_ctrl_pkg::br_ge;
          rv_isa_pkg::f3_bltu: branch = core_ctrl_pkg::br_ltu;
          rv_isa_pkg::f3_bgeu: branch = core_ctrl_pkg::br_geu;
          default:             illegal = 1'b1;
        endcase
      end
      default: illegal = 1'b1; // includes the all-zero halt word
    endcase
    if (illegal) begin
      branch    = core_ctrl_pkg::br_none;
      reg_write = 1'b0;
      mem_read  = 1'b0;
      mem_write = 1'b0;
    end
  end

  always_comb begin
    case (imm_fmt)
      core_ctrl_pkg::imm_s: imm = {{(rv_isa_pkg::xlen-12){inst[31]}}, inst[31:25], inst[11:7]};
      core_ctrl_pkg::imm_b: imm = {{(rv_isa_pkg::xlen-12){inst[31]}}, inst[7], inst[30:25],
                                   inst[11:8], 1'b0};
      core_ctrl_pkg::imm_u: imm = {inst[31:12], 12'b0};
      default:              imm = {{(rv_isa_pkg::xlen-12){inst[31]}}, inst[31:20]};
    endcase
  end

endmodule

`default_nettype wire

// ==== design/alu.sv ====
`default_nettype none

module alu (
  input  logic [rv_isa_pkg::xlen-1:0] rs1_data,
  input  logic [rv_isa_pkg::xlen-1:0] rs2_data,
  input  logic [rv_isa_pkg::xlen-1:0] imm,
  input  logic                        use_imm,
  input  core_ctrl_pkg::alu_op_t      alu_op,
  input  core_ctrl_pkg::branch_t      branch,
  output logic [rv_isa_pkg::xlen-1:0] result,
  output logic                        branch_taken
);

  logic [rv_isa_pkg::xlen-1:0] op_b;
  logic [4:0]                  shamt;

  assign op_b  = use_imm ? imm : rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (alu_op)
      core_ctrl_pkg::alu_add:      result = rs1_data + op_b;
      core_ctrl_pkg::alu_sub:      result = rs1_data - op_b;
      core_ctrl_pkg::alu_sll:      result = rs1_data << shamt;
      core_ctrl_pkg::alu_srl:      result = rs1_data >> shamt;
      core_ctrl_pkg::alu_sra:      result = $signed(rs1_data) >>> shamt;
      core_ctrl_pkg::alu_and:      result = rs1_data & op_b;
      core_ctrl_pkg::alu_or:       result = rs1_data | op_b;
      core_ctrl_pkg::alu_xor:      result = rs1_data ^ op_b;
      core_ctrl_pkg::alu_slt:      result = {{(rv_isa_pkg::xlen-1){1'b0}},
                                             $signed(rs1_data) < $signed(op_b)};
      core_ctrl_pkg::alu_sltu:     result = {{(rv_isa_pkg::xlen-1){1'b0}}, rs1_data < op_b};
      core_ctrl_pkg::alu_pass_imm: result = imm;
      default:                     result = '0;
    endcase
  end

  // compares straight on the register values, not on a subtract
  always_comb begin
    case (branch)
      core_ctrl_pkg::br_eq:  branch_taken = (rs1_data == rs2_data);
      core_ctrl_pkg::br_ne:  branch_taken = (rs1_data != rs2_data);
      core_ctrl_pkg::br_lt:  branch_taken = ($signed(rs1_data) < $signed(rs2_data));
      core_ctrl_pkg::br_ge:  branch_taken = ($signed(rs1_data) >= $signed(rs2_data));
      core_ctrl_pkg::br_ltu: branch_taken = (rs1_data < rs2_data);
      core_ctrl_pkg::br_geu: branch_taken = (rs1_data >= rs2_data);
      default:               branch_taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== design/register_file.sv ====
`default_nettype none

module register_file (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [rv_isa_pkg::reg_addr_w-1:0] rs1,
  input  logic [rv_isa_pkg::reg_addr_w-1:0] rs2,
  input  logic [rv_isa_pkg::reg_addr_w-1:0] rd,
  input  logic                              we,
  input  logic [rv_isa_pkg::xlen-1:0]       wd,
  output logic [rv_isa_pkg::xlen-1:0]       rs1_data,
  output logic [rv_isa_pkg::xlen-1:0]       rs2_data
);

  localparam int num_regs = 2 ** rv_isa_pkg::reg_addr_w;

  logic [rv_isa_pkg::xlen-1:0] regs [num_regs];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin // x0 stays zero
      regs[rd] <= wd;
    end
  end

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

endmodule

`default_nettype wire

// ==== design/word_memory.sv ====
`default_nettype none

module word_memory #(
  parameter int words = 256
) (
  input  logic                        clk,
  input  logic [rv_isa_pkg::xlen-1:0] rd_addr, // word index
  output logic [rv_isa_pkg::xlen-1:0] rd_data,
  input  logic                        we,
  input  logic [rv_isa_pkg::xlen-1:0] wr_addr,
  input  logic [rv_isa_pkg::xlen-1:0] wr_data
);

  localparam int addr_w = $clog2(words);

  logic [rv_isa_pkg::xlen-1:0] mem [words];
  logic [addr_w-1:0]           rd_idx;
  logic [addr_w-1:0]           wr_idx;

  assign rd_idx  = addr_w'(rd_addr % words);
  assign wr_idx  = addr_w'(wr_addr % words);
  assign rd_data = mem[rd_idx];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[wr_idx] <= wr_data;
    end
  end

endmodule

`default_nettype wire

// ==== design/pc_sequencer.sv ====
`default_nettype none

module pc_sequencer (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        run,
  input  logic                        mem_access,
  input  logic                        illegal,
  input  logic                        branch_taken,
  input  logic [rv_isa_pkg::xlen-1:0] imm,
  output logic [rv_isa_pkg::xlen-1:0] pc,
  output logic                        mem_wait,
  output logic                        commit,
  output logic                        halted
);

  logic active;

  assign active = run & ~halted;
  // memory ops finish in their wait cycle
  assign commit = active & ~illegal & (~mem_access | mem_wait);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc       <= '0;
      mem_wait <= 1'b0;
      halted   <= 1'b0;
    end else if (active) begin
      if (illegal) begin
        halted <= 1'b1; // sticky until reset
      end else if (commit) begin
        mem_wait <= 1'b0;
        if (branch_taken) begin
          pc <= pc + imm;
        end else begin
          pc <= pc + rv_isa_pkg::xlen'(4);
        end
      end else begin
        mem_wait <= 1'b1; // address cycle of lw/sw
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/rv_core.sv ====
`default_nettype none

module rv_core #(
  parameter int imem_words = 256,
  parameter int dmem_words = 64
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              run,
  input  logic                              load_en,
  input  logic                              load_dmem,
  input  logic [rv_isa_pkg::xlen-1:0]       load_addr,
  input  logic [rv_isa_pkg::xlen-1:0]       load_data,
  output logic                              retire_valid,
  output logic [rv_isa_pkg::xlen-1:0]       retire_pc,
  output logic [rv_isa_pkg::reg_addr_w-1:0] retire_rd,
  output logic [rv_isa_pkg::xlen-1:0]       retire_rd_data,
  output logic                              retire_store,
  output logic [rv_isa_pkg::xlen-1:0]       retire_addr,
  output logic [rv_isa_pkg::xlen-1:0]       retire_store_data,
  output logic                              halted
);

  logic [rv_isa_pkg::xlen-1:0]       pc, inst, imm;
  logic [rv_isa_pkg::reg_addr_w-1:0] rs1, rs2, rd;
  core_ctrl_pkg::alu_op_t            alu_op;
  core_ctrl_pkg::branch_t            branch;
  logic                              use_imm, reg_write, mem_read, mem_write, illegal;
  logic                              mem_wait, commit, branch_taken;
  logic [rv_isa_pkg::xlen-1:0]       rs1_data, rs2_data, alu_result, dmem_rd_data, wb_data;
  logic                              imem_we, dmem_we, store_now;
  logic [rv_isa_pkg::xlen-1:0]       dmem_wr_addr, dmem_wr_data;

  pc_sequencer pc_seq (
    .clk(clk), .rst(rst), .run(run),
    .mem_access(mem_read | mem_write), .illegal(illegal), .branch_taken(branch_taken),
    .imm(imm), .pc(pc), .mem_wait(mem_wait), .commit(commit), .halted(halted)
  );

  // load port owns both write ports while run is low
  assign imem_we      = ~run & load_en & ~load_dmem;
  assign store_now    = commit & mem_wait & mem_write;
  assign dmem_we      = run ? store_now : (load_en & load_dmem);
  assign dmem_wr_addr = run ? (alu_result >> 2) : load_addr;
  assign dmem_wr_data = run ? rs2_data : load_data;

  word_memory #(.words(imem_words)) imem (
    .clk(clk), .rd_addr(pc >> 2), .rd_data(inst),
    .we(imem_we), .wr_addr(load_addr), .wr_data(load_data)
  );

  word_memory #(.words(dmem_words)) dmem (
    .clk(clk), .rd_addr(alu_result >> 2), .rd_data(dmem_rd_data),
    .we(dmem_we), .wr_addr(dmem_wr_addr), .wr_data(dmem_wr_data)
  );

  inst_decoder dec (
    .inst(inst), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
    .alu_op(alu_op), .branch(branch), .use_imm(use_imm), .reg_write(reg_write),
    .mem_read(mem_read), .mem_write(mem_write), .illegal(illegal)
  );

  assign wb_data = mem_read ? dmem_rd_data : alu_result;

  register_file regs (
    .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .rd(rd),
    .we(commit & reg_write), .wd(wb_data), .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  alu alu_unit (
    .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm), .use_imm(use_imm),
    .alu_op(alu_op), .branch(branch), .result(alu_result), .branch_taken(branch_taken)
  );

  // rd shows 0 for sw and branches
  assign retire_valid      = commit;
  assign retire_pc         = pc;
  assign retire_rd         = reg_write ? rd : '0;
  assign retire_rd_data    = reg_write ? wb_data : '0;
  assign retire_store      = store_now;
  assign retire_addr       = alu_result; // byte address
  assign retire_store_data = rs2_data;

endmodule

`default_nettype wire

// ==== verification/rv_core_assertions.sv ====
`default_nettype none

module rv_core_assertions (
  input wire logic        clk,
  input wire logic        rst,
  input wire logic        run,
  input wire logic        halted,
  input wire logic        retire_valid,
  input wire logic [31:0] retire_pc,
  input wire logic        mem_read,
  input wire logic        mem_write,
  input wire logic        mem_wait,
  input wire logic        illegal
);

  timeunit 1ns;
  timeprecision 100ps;

  // a stopped or halted core neither retires nor moves its pc
  stopped_core_holds: assert property (@(posedge clk) disable iff (rst)
    (!run || halted) |-> !retire_valid ##1 $stable(retire_pc))
    else $error("core retired or moved its pc while run is low or it is halted");

  halt_is_sticky: assert property (@(posedge clk)
    $fell(halted) |-> rst)
    else $error("halted dropped without a reset");

  // address cycle of lw/sw is always followed by its retire
  mem_access_retires: assert property (@(posedge clk) disable iff (rst)
    (run && !halted && !illegal && (mem_read || mem_write) && !mem_wait)
      |=> (retire_valid || !run))
    else $error("data access did not retire in the cycle after its address cycle");

endmodule

`default_nettype wire

// ==== verification/rv_core_checker.sv ====
`default_nettype none

module rv_core_checker #(
  parameter int imem_words = 256,
  parameter int dmem_words = 64
) (
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire logic        load_en,
  input  wire logic        load_dmem,
  input  wire logic [31:0] load_addr,
  input  wire logic [31:0] load_data,
  input  wire logic        retire_valid,
  input  wire logic [31:0] retire_pc,
  input  wire logic [4:0]  retire_rd,
  input  wire logic [31:0] retire_rd_data,
  input  wire logic        retire_store,
  input  wire logic [31:0] retire_addr,
  input  wire logic [31:0] retire_store_data,
  input  wire logic        halted,
  output int               error_count,
  output int               retire_count,
  output logic             model_at_halt
);

  timeunit 1ns;
  timeprecision 100ps;

  logic [31:0] m_imem [imem_words];
  logic [31:0] m_dmem [dmem_words];
  logic [31:0] m_regs [32];
  logic [31:0] m_pc;

  assign model_at_halt = (m_imem[(m_pc >> 2) % imem_words] == 32'd0);

  function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_model(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b; // bgeu
    endcase
  endfunction

  task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      error_count++;
      $display("ERROR %0t: retire %0d at pc %h, %s is %h, expected %h",
               $time, retire_count, m_pc, what, got, exp);
    end
  endtask

  task automatic step_model();
    logic [31:0] inst, a, b, addr, exp_data, next_pc;
    logic [4:0]  rd;
    logic        store;
    inst     = m_imem[(m_pc >> 2) % imem_words];
    rd       = inst[11:7];
    a        = m_regs[inst[19:15]];
    b        = m_regs[inst[24:20]];
    exp_data = 32'd0;
    addr     = 32'd0;
    store    = 1'b0;
    next_pc  = m_pc + 32'd4;
    compare("pc", retire_pc, m_pc);
    case (inst[6:0])
      7'b0110011: exp_data = alu_model(inst[14:12], inst[30], a, b);
      7'b0010011: exp_data = alu_model(inst[14:12], inst[14:12] == 3'd5 && inst[30], a,
                                       {{20{inst[31]}}, inst[31:20]});
      7'b0000011: begin
        addr     = a + {{20{inst[31]}}, inst[31:20]};
        exp_data = m_dmem[(addr >> 2) % dmem_words];
      end
      7'b0100011: begin
        addr  = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
        store = 1'b1;
        rd    = 5'd0;
      end
      7'b0110111: exp_data = {inst[31:12], 12'd0};
      7'b1100011: begin
        rd = 5'd0;
        if (branch_model(inst[14:12], a, b)) begin
          next_pc = m_pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        end
      end
      default: begin
        error_count++;
        $display("model reached an instruction word it cannot execute: %h", inst);
      end
    endcase
    compare("rd", 32'(retire_rd), 32'(rd));
    if (rd != 5'd0) begin
      compare("rd_data", retire_rd_data, exp_data);
      m_regs[rd] = exp_data;
    end
    compare("store", 32'(retire_store), 32'(store));
    if (store) begin
      compare("store addr", retire_addr, addr);
      compare("store data", retire_store_data, b);
      m_dmem[(addr >> 2) % dmem_words] = b;
    end
    m_pc = next_pc;
    retire_count++;
  endtask

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        m_regs[i] = 32'd0;
      end
      m_pc         = 32'd0;
      error_count  = 0;
      retire_count = 0;
    end else begin
      if (load_en && load_dmem) begin
        m_dmem[load_addr % dmem_words] = load_data;
      end else if (load_en) begin
        m_imem[load_addr % imem_words] = load_data;
      end
      if (retire_valid && halted) begin
        error_count++;
        $display("retire seen while the core reports halted");
      end
      if (retire_valid) begin
        step_model();
      end
    end
  end

endmodule

`default_nettype wire

// ==== verification/rv_core_tb.sv ====
`default_nettype none

module rv_core_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int imem_words = 256;
  localparam int dmem_words = 64;
  localparam int num_insts  = 200;
  localparam int timeout_cycles = 10 + dmem_words + num_insts + 1 + 2 * num_insts + 100;

  logic        clk, rst, run, load_en, load_dmem;
  logic [31:0] load_addr, load_data;
  logic        retire_valid, retire_store, halted;
  logic [31:0] retire_pc, retire_rd_data, retire_addr, retire_store_data;
  logic [4:0]  retire_rd;

  int          checker_errors, retire_count, tb_errors, cycles, count_at_halt;
  logic        model_at_halt;
  logic [31:0] lfsr_state;
  logic [31:0] prog [num_insts];
  logic [31:0] data [dmem_words];

  rv_core #(.imem_words(imem_words), .dmem_words(dmem_words)) uut (
    .clk(clk), .rst(rst), .run(run),
    .load_en(load_en), .load_dmem(load_dmem), .load_addr(load_addr), .load_data(load_data),
    .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_rd(retire_rd),
    .retire_rd_data(retire_rd_data), .retire_store(retire_store), .retire_addr(retire_addr),
    .retire_store_data(retire_store_data), .halted(halted)
  );

  rv_core_checker #(.imem_words(imem_words), .dmem_words(dmem_words)) retire_check (
    .clk(clk), .rst(rst), .load_en(load_en), .load_dmem(load_dmem),
    .load_addr(load_addr), .load_data(load_data),
    .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_rd(retire_rd),
    .retire_rd_data(retire_rd_data), .retire_store(retire_store), .retire_addr(retire_addr),
    .retire_store_data(retire_store_data), .halted(halted),
    .error_count(checker_errors), .retire_count(retire_count), .model_at_halt(model_at_halt)
  );

  bind rv_core rv_core_assertions assertions (
    .clk(clk), .rst(rst), .run(run), .halted(halted), .retire_valid(retire_valid),
    .retire_pc(retire_pc), .mem_read(mem_read), .mem_write(mem_write),
    .mem_wait(mem_wait), .illegal(illegal)
  );

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = 32'd0;
    for (int k = 0; k < n; k++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r          = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic [4:0] reg_pick();
    return 5'(rand_bits(3)); // x0..x7 so operands collide often
  endfunction

  function automatic logic [31:0] gen_inst(input int index);
    logic [2:0]  br_f3 [6];
    logic [3:0]  kind;
    logic [2:0]  f3;
    logic [4:0]  rd, rs1, rs2;
    logic [11:0] imm;
    logic [12:0] boff;
    logic        alt;
    br_f3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    kind  = 4'(rand_bits(4));
    rd    = reg_pick();
    rs1   = reg_pick();
    rs2   = reg_pick();
    f3    = 3'(rand_bits(3));
    alt   = rand_bits(1) == 32'd1;
    if (kind >= 4'd14 && index >= num_insts - 3) begin
      kind = 4'd9; // branch here could jump past the halt word
    end
    if (kind <= 4'd4) begin
      alt = alt && (f3 == 3'd0 || f3 == 3'd5);
      return {alt ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd, 7'b0110011};
    end else if (kind <= 4'd8) begin
      imm = 12'(rand_bits(12));
      if (f3 == 3'd1) begin
        imm = {7'd0, imm[4:0]};
      end else if (f3 == 3'd5) begin
        imm = {alt ? 7'b0100000 : 7'b0000000, imm[4:0]};
      end
      return {imm, rs1, f3, rd, 7'b0010011};
    end else if (kind == 4'd9) begin
      return {20'(rand_bits(20)), rd, 7'b0110111};
    end else if (kind <= 4'd11) begin
      imm = 12'(rand_bits(6) * 4);
      return {imm, 5'd0, 3'b010, rd, 7'b0000011};
    end else if (kind <= 4'd13) begin
      imm = 12'(rand_bits(6) * 4);
      return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
    end
    boff = alt ? 13'd12 : 13'd8;
    f3   = br_f3[int'(rand_bits(3)) % 6];
    return {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], 7'b1100011};
  endfunction

  task automatic write_word(input logic to_dmem, input int addr, input logic [31:0] value);
    @(posedge clk);
    #1;
    load_en   = 1'b1;
    load_dmem = to_dmem;
    load_addr = 32'(addr);
    load_data = value;
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > timeout_cycles) begin
      $display("timeout: core did not halt within %0d cycles", timeout_cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    rst        = 1'b1;
    run        = 1'b0;
    load_en    = 1'b0;
    load_dmem  = 1'b0;
    load_addr  = 32'd0;
    load_data  = 32'd0;
    tb_errors  = 0;
    cycles     = 0;
    lfsr_state = 32'd44;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int i = 0; i < dmem_words; i++) begin
      data[i] = rand_bits(32);
      write_word(1'b1, i, data[i]);
    end
    for (int i = 0; i < num_insts; i++) begin
      prog[i] = gen_inst(i);
      write_word(1'b0, i, prog[i]);
    end
    write_word(1'b0, num_insts, 32'd0); // halt word
    @(posedge clk);
    #1;
    load_en = 1'b0;
    run     = 1'b1;
    do begin
      @(posedge clk);
      #1;
    end while (!halted);
    count_at_halt = retire_count;
    repeat (5) @(posedge clk);
    #1;
    if (retire_count != count_at_halt) begin
      tb_errors++;
      $display("core kept retiring after it halted");
    end
    if (model_at_halt !== 1'b1) begin
      tb_errors++;
      $display("core halted after %0d retires but the model has not reached the halt word",
               retire_count);
    end
    $display("retired %0d, checker errors %0d, testbench errors %0d",
             retire_count, checker_errors, tb_errors);
    if (checker_errors == 0 && tb_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
design/rv_isa_pkg.sv
design/core_ctrl_pkg.sv
design/inst_decoder.sv
design/alu.sv
design/register_file.sv
design/word_memory.sv
design/pc_sequencer.sv
design/rv_core.sv
verification/rv_core_assertions.sv
verification/rv_core_checker.sv
verification/rv_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module rv_core_tb -o rv_core_sim

output=$(./obj_dir/rv_core_sim)
echo "$output"

if echo "$output" | grep -q "TEST RESULT: PASS"; then
  exit 0
fi
exit 1
